/* hdl/mailbox_pkg.sv */
//##########################################################
// Shared types and constants for the mesh node mailbox
// Modules pull these in with a wildcard import
//##########################################################
package mailbox_pkg;

   //##########################################################
   // Mesh transaction
   //##########################################################

   // One mesh transaction, 104 bits, write bit on top
   typedef struct packed {
      logic        write;      // 1 = write, 0 = read
      logic [1:0]  datamode;   // Transfer size code
      logic [4:0]  ctrlmode;   // Mesh control field
      logic [31:0] dstaddr;    // Target address
      logic [31:0] data;       // Write data, low message word
      logic [31:0] srcaddr;    // Source address, high message word
   } mesh_packet_t;

   // Mailbox entry as held in the FIFO
   typedef struct packed {
      logic [31:0] msg_hi;     // From srcaddr
      logic [31:0] msg_lo;     // From data
   } mailbox_msg_t;

   typedef logic [31:0] reg_word_t;   // Register read word

   //##########################################################
   // Address decode fields
   //##########################################################

   localparam logic [11:0] node_id    = 12'h810;  // dstaddr[31:20]
   localparam logic [3:0]  group_mmr  = 4'hf;     // dstaddr[19:16]
   localparam logic [2:0]  group_mesh = 3'h5;     // dstaddr[10:8]

   // Register index lives in dstaddr[7:2]
   localparam int reg_aw = 6;

   localparam logic [reg_aw-1:0] reg_mailbox_lo   = 6'd9;    // Pops on read
   localparam logic [reg_aw-1:0] reg_mailbox_hi   = 6'd10;   // Peek only
   localparam logic [reg_aw-1:0] reg_mailbox_stat = 6'd11;   // Full, not-empty

   //##########################################################
   // FIFO sizing
   //##########################################################

   localparam int fifo_depth = 32;                  // Power of two
   localparam int fifo_aw    = $clog2(fifo_depth);  // Entry address bits

endpackage

/* hdl/mesh_write_decode.sv */
//##########################################################
// Mailbox producer on the wr_clk side
// Filters mesh writes aimed at the mailbox, emits FIFO writes
//##########################################################
`timescale 1ns/1ns

module mesh_write_decode
   import mailbox_pkg::*;
(
   input  logic         wr_clk,
   input  logic         arst_n,
   input  logic         emesh_access,   // One-cycle strobe
   input  mesh_packet_t emesh_packet,
   output logic         wr_en,          // One-cycle FIFO write
   output mailbox_msg_t wr_msg
);

   logic         access_q;   // Input stage strobe
   mesh_packet_t packet_q;   // Input stage packet
   logic         hit;        // Mailbox write decoded

   // Input stage
   always_ff @(posedge wr_clk or negedge arst_n)
   begin
      if (!arst_n)
         access_q <= 1'b0;
      else
         access_q <= emesh_access;
   end

   always_ff @(posedge wr_clk)
   begin
      packet_q <= emesh_packet;
   end

   // Full address match on the mailbox low register
   assign hit = access_q & packet_q.write &
                (packet_q.dstaddr[31:20]       == node_id) &
                (packet_q.dstaddr[19:16]       == group_mmr) &
                (packet_q.dstaddr[10:8]        == group_mesh) &
                (packet_q.dstaddr[reg_aw+1:2]  == reg_mailbox_lo);

   // Output stage, strobe
   always_ff @(posedge wr_clk or negedge arst_n)
   begin
      if (!arst_n)
         wr_en <= 1'b0;
      else
         wr_en <= hit;
   end

   // Output stage, message words
   always_ff @(posedge wr_clk)
   begin
      if (hit)
      begin
         wr_msg.msg_hi <= packet_q.srcaddr;
         wr_msg.msg_lo <= packet_q.data;
      end
   end

   // Message must be settled by the time the FIFO samples it
   a_msg_known : assert property (@(posedge wr_clk) disable iff (!arst_n)
      wr_en |-> !$isunknown(wr_msg))
      else $error("mailbox write with unknown message");

endmodule

/* hdl/mailbox_fifo_async.sv */
//##########################################################
// Dual-clock FIFO with gray pointers, head shown fall-through
// Payload type is a parameter, depth comes from the package
//##########################################################
`timescale 1ns/1ns

module mailbox_fifo_async
   import mailbox_pkg::*;
#(
   parameter type payload_t = mailbox_msg_t
)
(
   input  logic     wr_clk,
   input  logic     rd_clk,
   input  logic     arst_n,    // Clears both domains
   input  logic     wr_en,
   input  payload_t din,
   output logic     full,      // rd_clk domain copy
   input  logic     rd_en,
   output payload_t dout,      // Current head
   output logic     empty      // rd_clk domain
);

   payload_t         mem [fifo_depth];   // Storage array

   logic [fifo_aw:0] wr_bin;          // Write pointer, extra wrap bit
   logic [fifo_aw:0] wr_bin_nxt;
   logic [fifo_aw:0] wr_gray;
   logic [fifo_aw:0] wr_gray_nxt;
   logic [fifo_aw:0] rd_bin;          // Read pointer, extra wrap bit
   logic [fifo_aw:0] rd_bin_nxt;
   logic [fifo_aw:0] rd_gray;
   logic [fifo_aw:0] rd_gray_nxt;
   logic [fifo_aw:0] wr_gray_rs1;     // Write pointer into rd_clk
   logic [fifo_aw:0] wr_gray_rs2;
   logic [fifo_aw:0] rd_gray_ws1;     // Read pointer into wr_clk
   logic [fifo_aw:0] rd_gray_ws2;
   logic             full_wr;         // Write gating only
   logic             wr_go;
   logic             rd_go;

   //##########################################################
   // Write domain
   //##########################################################

   assign wr_go       = wr_en & ~full_wr;   // Writes while full are lost
   assign wr_bin_nxt  = wr_bin + {{fifo_aw{1'b0}}, wr_go};
   assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

   always_ff @(posedge wr_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_bin      <= '0;
         wr_gray     <= '0;
         rd_gray_ws1 <= '0;
         rd_gray_ws2 <= '0;
      end
      else
      begin
         wr_bin      <= wr_bin_nxt;
         wr_gray     <= wr_gray_nxt;
         rd_gray_ws1 <= rd_gray;        // Two-flop sync
         rd_gray_ws2 <= rd_gray_ws1;
      end
   end

   always_ff @(posedge wr_clk)
   begin
      if (wr_go)
         mem[wr_bin[fifo_aw-1:0]] <= din;
   end

   // Full when pointers differ only in the top two gray bits
   assign full_wr = (wr_gray == {~rd_gray_ws2[fifo_aw:fifo_aw-1],
                                 rd_gray_ws2[fifo_aw-2:0]});

   //##########################################################
   // Read domain
   //##########################################################

   assign rd_go       = rd_en & ~empty;
   assign rd_bin_nxt  = rd_bin + {{fifo_aw{1'b0}}, rd_go};
   assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

   always_ff @(posedge rd_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rd_bin      <= '0;
         rd_gray     <= '0;
         wr_gray_rs1 <= '0;
         wr_gray_rs2 <= '0;
      end
      else
      begin
         rd_bin      <= rd_bin_nxt;
         rd_gray     <= rd_gray_nxt;
         wr_gray_rs1 <= wr_gray;        // Two-flop sync
         wr_gray_rs2 <= wr_gray_rs1;
      end
   end

   assign empty = (rd_gray == wr_gray_rs2);
   // Local read pointer against synced write pointer, drops at once on a pop
   assign full  = (wr_gray_rs2 == {~rd_gray[fifo_aw:fifo_aw-1],
                                   rd_gray[fifo_aw-2:0]});
   assign dout  = mem[rd_bin[fifo_aw-1:0]];

   //##########################################################
   // Protocol checks
   //##########################################################

   a_no_wr_full : assert property (@(posedge wr_clk) disable iff (!arst_n)
      wr_en |-> !full_wr)
      else $error("mailbox write while full, entry dropped");

   a_no_rd_empty : assert property (@(posedge rd_clk) disable iff (!arst_n)
      rd_en |-> !empty)
      else $error("mailbox pop while empty");

endmodule

/* hdl/mailbox_reg_read.sv */
//##########################################################
// Mailbox consumer on the rd_clk side
// Register reads of low, high and status words plus the irq
//##########################################################
`timescale 1ns/1ns

module mailbox_reg_read
   import mailbox_pkg::*;
(
   input  logic         rd_clk,
   input  logic         arst_n,
   input  logic         reg_access,      // One-cycle strobe
   input  mesh_packet_t reg_packet,
   input  logic         mailbox_irq_en,
   input  mailbox_msg_t rd_msg,          // FIFO head
   input  logic         empty,
   input  logic         full,
   output logic         rd_en,           // Pop strobe
   output reg_word_t    reg_rdata,       // Valid one cycle after strobe
   output logic         mailbox_irq      // Level
);

   logic [reg_aw-1:0] reg_idx;    // Register index from dstaddr
   logic              reg_read;
   logic              sel_lo;
   logic              sel_hi;
   logic              sel_stat;
   reg_word_t         rdata_nxt;

   assign reg_idx  = reg_packet.dstaddr[reg_aw+1:2];
   assign reg_read = reg_access & ~reg_packet.write;   // Reads only

   assign sel_lo   = reg_read & (reg_idx == reg_mailbox_lo);
   assign sel_hi   = reg_read & (reg_idx == reg_mailbox_hi);
   assign sel_stat = reg_read & (reg_idx == reg_mailbox_stat);

   // Low read pops unless empty, so the stale head stays put
   assign rd_en = sel_lo & ~empty;

   //##########################################################
   // Read data mux
   //##########################################################

   always_comb
   begin
      rdata_nxt = '0;                              // Unmapped or idle
      if (sel_stat)
         rdata_nxt = {30'b0, full, ~empty};
      else if (sel_hi)
         rdata_nxt = rd_msg.msg_hi;
      else if (sel_lo)
         rdata_nxt = rd_msg.msg_lo;                // Head before the pop
   end

   always_ff @(posedge rd_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         reg_rdata   <= '0;
         mailbox_irq <= 1'b0;
      end
      else
      begin
         reg_rdata   <= rdata_nxt;
         mailbox_irq <= mailbox_irq_en & (~empty | full);   // Level irq
      end
   end

   // A strobe with an unknown command or index could pop by accident
   a_access_known : assert property (@(posedge rd_clk) disable iff (!arst_n)
      reg_access |-> !$isunknown({reg_packet.write, reg_idx}))
      else $error("register access with unknown command or index");

endmodule

/* hdl/mailbox_top.sv */
//##########################################################
// Mesh mailbox top, write decoder into FIFO into read port
// Mesh writes on wr_clk, register reads and irq on rd_clk
//##########################################################
`timescale 1ns/1ns

module mailbox_top
   import mailbox_pkg::*;
(
   input  logic         wr_clk,
   input  logic         rd_clk,
   input  logic         arst_n,
   input  logic         emesh_access,    // Message write strobe
   input  mesh_packet_t emesh_packet,
   input  logic         reg_access,      // Register read strobe
   input  mesh_packet_t reg_packet,
   input  logic         mailbox_irq_en,
   output reg_word_t    reg_rdata,
   output logic         mailbox_irq
);

   logic         wr_en;    // wr_clk domain
   mailbox_msg_t wr_msg;
   logic         rd_en;    // rd_clk domain
   mailbox_msg_t rd_msg;
   logic         empty;
   logic         full;

   // Producer
   mesh_write_decode u_write_decode (
      .wr_clk       (wr_clk),
      .arst_n       (arst_n),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .wr_en        (wr_en),
      .wr_msg       (wr_msg)
   );

   // Buffer across clock domains
   mailbox_fifo_async #(
      .payload_t (mailbox_msg_t)
   ) u_fifo (
      .wr_clk (wr_clk),
      .rd_clk (rd_clk),
      .arst_n (arst_n),
      .wr_en  (wr_en),
      .din    (wr_msg),
      .full   (full),
      .rd_en  (rd_en),
      .dout   (rd_msg),
      .empty  (empty)
   );

   // Consumer
   mailbox_reg_read u_reg_read (
      .rd_clk         (rd_clk),
      .arst_n         (arst_n),
      .reg_access     (reg_access),
      .reg_packet     (reg_packet),
      .mailbox_irq_en (mailbox_irq_en),
      .rd_msg         (rd_msg),
      .empty          (empty),
      .full           (full),
      .rd_en          (rd_en),
      .reg_rdata      (reg_rdata),
      .mailbox_irq    (mailbox_irq)
   );

endmodule

/* dv/mailbox_tb.sv */
//##########################################################
// Directed testbench for the mesh mailbox top level
// Mesh writes on wr_clk, register reads and irq on rd_clk
//##########################################################
`timescale 1ns/1ns

module mailbox_tb
   import mailbox_pkg::*;
();

   localparam int timeout_cycles = 4000;   // Well above the tests' total length

   logic         rd_clk = 1'b0;
   logic         wr_clk = 1'b0;
   logic         arst_n;
   logic         emesh_access;
   mesh_packet_t emesh_packet;
   logic         reg_access;
   mesh_packet_t reg_packet;
   logic         mailbox_irq_en;
   reg_word_t    reg_rdata;
   logic         mailbox_irq;

   mailbox_msg_t q[$];            // Expected mailbox contents in arrival order
   integer       seed = 32'h335a;
   int           errors = 0;
   int           cycles = 0;

   always #20 rd_clk = ~rd_clk;   // 40 ns
   always #14 wr_clk = ~wr_clk;   // 28 ns

   mailbox_top dut (.*);

   //##########################################################
   // Drivers
   //##########################################################

   // Mesh address of a mailbox register
   function automatic logic [31:0] mbox_addr(input logic [reg_aw-1:0] idx);
      return {node_id, group_mmr, 5'b0, group_mesh, idx, 2'b00};
   endfunction

   task automatic send_msg(input logic [31:0] hi, lo, dst, input logic wr);
      @(posedge wr_clk);
      emesh_access <= 1'b1;
      emesh_packet <= '{write: wr, datamode: 2'b10, ctrlmode: 5'd0,
                        dstaddr: dst, data: lo, srcaddr: hi};
      @(posedge wr_clk);
      emesh_access <= 1'b0;   // One-cycle strobe
   endtask

   // Valid mailbox write that also enters the reference queue
   task automatic post_msg(input logic [31:0] hi, lo);
      send_msg(hi, lo, mbox_addr(reg_mailbox_lo), 1'b1);
      q.push_back({hi, lo});
   endtask

   task automatic reg_read(input logic [reg_aw-1:0] idx, output reg_word_t data);
      @(posedge rd_clk);
      reg_access <= 1'b1;
      reg_packet <= '{write: 1'b0, datamode: 2'b10, ctrlmode: 5'd0,
                      dstaddr: mbox_addr(idx), data: 32'd0, srcaddr: 32'd0};
      @(posedge rd_clk);                  // Sampled here
      reg_access <= 1'b0;
      @(negedge rd_clk);                  // Data settled mid-cycle
      data = reg_rdata;
   endtask

   //##########################################################
   // Checks
   //##########################################################

   task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_irq(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_status(input string name, input reg_word_t exp);
      reg_word_t st;
      reg_read(reg_mailbox_stat, st);
      check_word(name, st, exp);
   endtask

   // Polls status until bit b sets or the poll limit runs out
   task automatic wait_status(input int b, input string what);
      reg_word_t st;
      int        polls;
      st    = '0;
      polls = 0;
      while (st[b] !== 1'b1 && polls < 40)
      begin
         reg_read(reg_mailbox_stat, st);
         polls++;
      end
      if (st[b] !== 1'b1)
      begin
         errors++;
         $display("%s never showed up in the status word", what);
      end
   endtask

   task automatic wait_not_empty();
      wait_status(0, "not-empty");
   endtask

   // High then low read against the queue head
   task automatic pop_and_check(input string tag);
      mailbox_msg_t exp;
      reg_word_t    hi;
      reg_word_t    lo;
      exp = q.pop_front();
      reg_read(reg_mailbox_hi, hi);
      reg_read(reg_mailbox_lo, lo);
      check_word({tag, " msg_hi"}, hi, exp.msg_hi);
      check_word({tag, " msg_lo"}, lo, exp.msg_lo);
   endtask

   //##########################################################
   // Directed tests
   //##########################################################

   task automatic order_and_content();
      logic [31:0] hi;
      logic [31:0] lo;
      for (int i = 0; i < 5; i++)
      begin
         hi = $random(seed);
         lo = $random(seed);
         post_msg(hi, lo);
      end
      for (int i = 0; i < 5; i++)
      begin
         wait_not_empty();
         pop_and_check("order");
      end
      check_status("status after drain", 32'h0);
   endtask

   task automatic address_filtering();
      logic [31:0] a;
      a = mbox_addr(reg_mailbox_lo);
      send_msg(32'h1111_0001, 32'h2222_0001, a ^ 32'h0010_0000, 1'b1);  // Node ID
      send_msg(32'h1111_0002, 32'h2222_0002, a ^ 32'h0001_0000, 1'b1);  // Group
      send_msg(32'h1111_0003, 32'h2222_0003, a ^ 32'h0000_0100, 1'b1);  // Subgroup
      send_msg(32'h1111_0004, 32'h2222_0004, mbox_addr(reg_mailbox_hi), 1'b1);
      send_msg(32'h1111_0005, 32'h2222_0005, a, 1'b0);                  // Read packet
      repeat (8) @(posedge rd_clk);       // Longer than pointer sync
      check_status("status after dropped writes", 32'h0);
      post_msg(32'hcafe_0001, 32'hbeef_0001);
      wait_not_empty();
      pop_and_check("filter");
      check_status("status after filter pop", 32'h0);
   endtask

   task automatic peek_without_pop();
      reg_word_t w;
      post_msg(32'h0a0a_0001, 32'h0b0b_0001);
      post_msg(32'h0a0a_0002, 32'h0b0b_0002);
      wait_not_empty();
      for (int i = 0; i < 3; i++)
      begin
         reg_read(reg_mailbox_hi, w);
         check_word("repeated msg_hi", w, q[0].msg_hi);
      end
      check_status("status while waiting", 32'h1);
      pop_and_check("peek first");
      wait_not_empty();
      pop_and_check("peek second");
   endtask

   task automatic full_flag();
      for (int i = 0; i < fifo_depth; i++)
         post_msg(32'hf000_0000 | i, ~(32'hf000_0000 | i));
      wait_status(1, "full flag");
      check_status("status when full", 32'h3);   // Full and not empty
      for (int i = 0; i < fifo_depth; i++)
         pop_and_check("drain");
      check_status("status after full drain", 32'h0);
   endtask

   task automatic interrupt_level();
      reg_word_t w;
      int        polls;
      post_msg(32'h5151_0001, 32'h7171_0001);
      wait_not_empty();
      @(negedge rd_clk);
      check_irq("mailbox_irq disabled", mailbox_irq, 1'b0);
      @(posedge rd_clk);
      mailbox_irq_en <= 1'b1;
      @(posedge rd_clk);                  // Registered level catches up
      @(negedge rd_clk);
      check_irq("mailbox_irq pending", mailbox_irq, 1'b1);
      reg_read(6'd3, w);                  // Unmapped index
      check_word("unmapped read", w, 32'h0);
      pop_and_check("irq");
      polls = 0;
      while (mailbox_irq !== 1'b0 && polls < 6)
      begin
         @(negedge rd_clk);
         polls++;
      end
      check_irq("mailbox_irq after pop", mailbox_irq, 1'b0);
      @(posedge rd_clk);
      mailbox_irq_en <= 1'b0;
   endtask

   //##########################################################
   // Run control
   //##########################################################

   initial
   begin
      while (cycles < timeout_cycles)
      begin
         @(posedge rd_clk);
         cycles++;
      end
      $display("timeout after %0d rd_clk cycles, tests did not finish", cycles);
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      arst_n         = 1'b0;
      emesh_access   = 1'b0;
      emesh_packet   = '0;
      reg_access     = 1'b0;
      reg_packet     = '0;
      mailbox_irq_en = 1'b0;
      repeat (8) @(posedge rd_clk);
      arst_n <= 1'b1;
      order_and_content();
      address_filtering();
      peek_without_pop();
      full_flag();
      interrupt_level();
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

/* sources.f */
hdl/mailbox_pkg.sv
hdl/mesh_write_decode.sv
hdl/mailbox_fifo_async.sv
hdl/mailbox_reg_read.sv
hdl/mailbox_top.sv
dv/mailbox_tb.sv

/* run.sh */
#!/bin/sh
# Build the mailbox testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module mailbox_tb -o mailbox_sim

out=$(./obj_dir/mailbox_sim)
echo "$out"
echo "$out" | grep -q "TESTS PASSED"
